//--- fdc_bus_pkg.sv
package fdc_bus_pkg;

	// ----------------------------------------
	// host side types
	// ----------------------------------------

	// one register byte as the host sees it
	typedef logic [7:0] byte_t;

	// host port address, three bits wide
	typedef logic [2:0] reg_addr_t;

	// upper nibble of a command byte
	typedef logic [3:0] cmd_nibble_t;

	// ----------------------------------------
	// register map
	// ----------------------------------------

	// command on write, status on read
	localparam reg_addr_t A_CMD_STATUS = 3'b000;
	localparam reg_addr_t A_TRACK      = 3'b001;
	localparam reg_addr_t A_SECTOR     = 3'b010;
	localparam reg_addr_t A_DATA       = 3'b011;
	// drive in bit 0, side in bit 2
	localparam reg_addr_t A_CTL2       = 3'b111;

	// ----------------------------------------
	// command classes
	// ----------------------------------------

	localparam cmd_nibble_t CMD_RESTORE   = 4'h0;
	localparam cmd_nibble_t CMD_SEEK      = 4'h1;
	// read and write sector take the next nibble too
	localparam cmd_nibble_t CMD_READ      = 4'h8;
	localparam cmd_nibble_t CMD_WRITE     = 4'hA;
	localparam cmd_nibble_t CMD_FORCE_INT = 4'hD;

endpackage

//--- fdc_work_pkg.sv
package fdc_work_pkg;

	// ----------------------------------------
	// workhorse request codes
	// ----------------------------------------

	// nothing asked, the workhorse may idle
	localparam logic [7:0] REQ_IDLE  = 8'h00;

	// sector read, drive and side in the low bits
	localparam logic [7:0] REQ_READ  = 8'h10;

	// sector write, side in bit 0
	localparam logic [7:0] REQ_WRITE = 8'h20;

	// type I command, nibble in the low bits
	localparam logic [7:0] REQ_NOP   = 8'h40;

	// end of command, workhorse clears its status
	localparam logic [7:0] REQ_ACK   = 8'h80;

	// ----------------------------------------
	// workhorse status bits
	// ----------------------------------------

	// request finished
	localparam int WS_DONE      = 0;
	// finished without trouble
	localparam int WS_OK        = 1;
	// crc problem, only meaningful with a failure
	localparam int WS_CRC       = 2;
	// no image loaded, counts as failure
	localparam int WS_NOT_READY = 3;

	// ----------------------------------------
	// sector buffer
	// ----------------------------------------

	// address into the 1 KB buffer
	typedef logic [9:0] buf_addr_t;

	// byte count, wide enough for a full 1024 byte sector
	typedef logic [10:0] xfer_len_t;

endpackage

//--- fdc_if.sv
`timescale 1ns/1ps

// command handshake and register values between host block and sequencer
interface fdc_ctl_if;
	import fdc_bus_pkg::*;

	// host block side
	byte_t cmd;
	logic  cmd_valid;
	logic  force_int;
	logic  status_read;
	byte_t track_reg;
	byte_t sector_reg;
	logic  side;
	logic  drive;

	// sequencer side
	logic  cmd_take;
	logic  track_load;
	byte_t track_value;
	logic  busy;
	byte_t status;

	modport host (
		output cmd, cmd_valid, force_int, status_read,
		output track_reg, sector_reg, side, drive,
		input  cmd_take, track_load, track_value, busy, status
	);

	modport sequencer (
		input  cmd, cmd_valid, force_int, status_read,
		input  track_reg, side, drive,
		output cmd_take, track_load, track_value, busy, status
	);
endinterface

// start/stop of the byte engine and its results
interface fdc_xfer_if;
	import fdc_bus_pkg::*;

	logic  start_read;
	logic  start_write;
	logic  stop;
	logic  done;
	logic  lost;
	logic  drq;
	byte_t data_reg;

	modport sequencer (
		output start_read, start_write, stop,
		input  done, lost, drq, data_reg
	);

	modport engine (
		input  start_read, start_write, stop,
		output done, lost, drq, data_reg
	);
endinterface

//--- fdc_host_regs.sv
`timescale 1ns/1ps

module fdc_host_regs (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   rd,
	input  logic                   wr,
	input  fdc_bus_pkg::reg_addr_t addr,
	input  fdc_bus_pkg::byte_t     idata,
	output fdc_bus_pkg::byte_t     odata,
	output logic                   data_rd,
	output logic                   data_wr,
	output fdc_bus_pkg::byte_t     data_in,
	fdc_ctl_if.host                ctl,
	input  fdc_bus_pkg::byte_t     data_reg
);
	import fdc_bus_pkg::*;

	logic wr_cmd;
	logic is_force;

	// ----------------------------------------
	// strobe decode
	// ----------------------------------------

	assign wr_cmd   = wr && (addr == A_CMD_STATUS);
	assign is_force = (idata[7:4] == CMD_FORCE_INT);

	// data port strobes go straight to the byte engine
	assign data_rd = rd && (addr == A_DATA);
	assign data_wr = wr && (addr == A_DATA);
	assign data_in = idata;

	// force-interrupt bypasses the pending latch
	assign ctl.force_int   = wr_cmd && is_force;
	// sequencer clears the index bit on this
	assign ctl.status_read = rd && (addr == A_CMD_STATUS);

	// ----------------------------------------
	// registers
	// ----------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ctl.track_reg  <= 8'h00;
			ctl.sector_reg <= 8'h00;
			ctl.side       <= 1'b0;
			ctl.drive      <= 1'b0;
			ctl.cmd_valid  <= 1'b0;
		end else begin
			// type I commands may rewrite the track register
			if (ctl.track_load)
				ctl.track_reg <= ctl.track_value;
			else if (wr && addr == A_TRACK && !ctl.busy)
				ctl.track_reg <= idata;

			if (wr && addr == A_SECTOR && !ctl.busy)
				ctl.sector_reg <= idata;

			if (wr && addr == A_CTL2) begin
				ctl.side  <= idata[2];
				ctl.drive <= idata[0];
			end

			// pending flag, dropped once the sequencer takes it
			if (ctl.cmd_take)
				ctl.cmd_valid <= 1'b0;
			// second command while one waits is lost
			if (wr_cmd && !is_force && !ctl.cmd_valid)
				ctl.cmd_valid <= 1'b1;
		end
	end

	// command byte itself
	always_ff @(posedge clk) begin
		if (wr_cmd && !is_force && !ctl.cmd_valid)
			ctl.cmd <= idata;
	end

	// ----------------------------------------
	// readback
	// ----------------------------------------

	always_comb begin
		case (addr)
			A_CMD_STATUS: odata = ctl.status;
			A_TRACK:      odata = ctl.track_reg;
			A_SECTOR:     odata = ctl.sector_reg;
			A_DATA:       odata = data_reg;
			// unused bits of ctl2 read high
			A_CTL2:       odata = {5'b11111, ctl.side, 1'b0, ctl.drive};
			default:      odata = 8'hFF;
		endcase
	end

	// sequencer only takes what was latched here
	a_take_needs_valid: assert property (
		@(posedge clk) disable iff (!reset_n) ctl.cmd_take |-> ctl.cmd_valid
	);

endmodule

//--- fdc_sequencer.sv
`timescale 1ns/1ps

module fdc_sequencer (
	input  logic               clk,
	input  logic               reset_n,
	fdc_ctl_if.sequencer       ctl,
	fdc_xfer_if.sequencer      xfer,
	output fdc_bus_pkg::byte_t cpu_track,
	output fdc_bus_pkg::byte_t cpu_request,
	input  fdc_bus_pkg::byte_t cpu_status
);
	import fdc_bus_pkg::*;
	import fdc_work_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_WAIT_NOP,
		S_WAIT_READ,
		S_READING,
		S_WRITING,
		S_WAIT_WRITE,
		S_ABORT,
		S_END_ACK,
		S_END_CLEAR
	} seq_state_t;

	seq_state_t  state;
	cmd_nibble_t nibble;

	// status sources
	logic cmd_mode;
	logic head_loaded;
	logic index_flag;
	logic not_ready;
	logic seek_err;
	logic crc_err;
	logic wr_fault;
	logic lost_data;

	// step helpers
	logic  step_dir;
	logic  step_out;
	byte_t head_next;
	byte_t track_next;

	logic ws_ok;
	logic ws_fail;
	logic busy_any;

	// ----------------------------------------
	// decode helpers
	// ----------------------------------------

	assign nibble = ctl.cmd[7:4];

	// bit 6 clear keeps the last direction, 1 steps toward track 0
	assign step_out   = ctl.cmd[6] ? ctl.cmd[5] : step_dir;
	assign head_next  = step_out ? cpu_track - 8'd1 : cpu_track + 8'd1;
	// track register follows by one step as well
	assign track_next = step_out ? ctl.track_reg - 8'd1 : ctl.track_reg + 8'd1;

	assign ws_ok   = cpu_status[WS_DONE] & cpu_status[WS_OK];
	assign ws_fail = (cpu_status[WS_DONE] & ~cpu_status[WS_OK]) | cpu_status[WS_NOT_READY];

	// a latched command already counts as busy for the host
	assign busy_any = ctl.busy | ctl.cmd_valid;

	// type I layout vs read/write layout
	assign ctl.status = cmd_mode ?
		{not_ready, 1'b0, wr_fault, seek_err, crc_err, lost_data, xfer.drq, busy_any} :
		{not_ready, 1'b0, head_loaded, seek_err, crc_err, cpu_track == 8'd0,
			index_flag, busy_any};

	// ----------------------------------------
	// command FSM
	// ----------------------------------------

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state            <= S_IDLE;
			cpu_track        <= 8'hFF;
			cpu_request      <= REQ_IDLE;
			ctl.busy         <= 1'b0;
			ctl.cmd_take     <= 1'b0;
			ctl.track_load   <= 1'b0;
			ctl.track_value  <= 8'h00;
			xfer.start_read  <= 1'b0;
			xfer.start_write <= 1'b0;
			xfer.stop        <= 1'b0;
			cmd_mode         <= 1'b0;
			step_dir         <= 1'b0;
			head_loaded      <= 1'b0;
			index_flag       <= 1'b0;
			not_ready        <= 1'b0;
			seek_err         <= 1'b0;
			crc_err          <= 1'b0;
			wr_fault         <= 1'b0;
			lost_data        <= 1'b0;
		end else begin
			// one-cycle pulses
			ctl.cmd_take     <= 1'b0;
			ctl.track_load   <= 1'b0;
			xfer.start_read  <= 1'b0;
			xfer.start_write <= 1'b0;
			xfer.stop        <= 1'b0;

			not_ready <= cpu_status[WS_NOT_READY];
			if (ctl.status_read)
				index_flag <= 1'b0;

			case (state)
				S_IDLE: begin
					if (ctl.cmd_valid) begin
						ctl.cmd_take <= 1'b1;
						cmd_mode     <= ctl.cmd[7];
						// common part of every type I command
						if (!ctl.cmd[7]) begin
							head_loaded <= ctl.cmd[3];
							index_flag  <= 1'b1;
							ctl.busy    <= 1'b1;
							cpu_request <= REQ_NOP | {4'h0, nibble};
							state       <= S_WAIT_NOP;
						end
						case (nibble)
							CMD_RESTORE: begin
								cpu_track       <= 8'h00;
								ctl.track_load  <= 1'b1;
								ctl.track_value <= 8'h00;
							end
							CMD_SEEK: begin
								// head lands on the data register value
								cpu_track       <= xfer.data_reg;
								ctl.track_load  <= 1'b1;
								ctl.track_value <= xfer.data_reg;
							end
							4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
								if (ctl.cmd[6])
									step_dir <= ctl.cmd[5];
								cpu_track <= head_next;
								// bit 4 asks for track update
								if (ctl.cmd[4]) begin
									ctl.track_load  <= 1'b1;
									ctl.track_value <= track_next;
								end
							end
							CMD_READ, CMD_READ | 4'h1: begin
								{wr_fault, seek_err, crc_err, lost_data} <= 4'b0000;
								ctl.busy    <= 1'b1;
								cpu_request <= REQ_READ | {6'b0, ctl.drive, ctl.side};
								state       <= S_WAIT_READ;
							end
							CMD_WRITE, CMD_WRITE | 4'h1: begin
								{wr_fault, seek_err, crc_err, lost_data} <= 4'b0000;
								ctl.busy         <= 1'b1;
								xfer.start_write <= 1'b1;
								state            <= S_WRITING;
							end
							// read address and track ops are not handled
							default: ;
						endcase
					end
				end

				S_WAIT_NOP: begin
					if (cpu_status[WS_DONE])
						state <= S_END_ACK;
				end

				// workhorse fills the buffer first
				S_WAIT_READ: begin
					if (ws_fail) begin
						seek_err <= 1'b1;
						crc_err  <= cpu_status[WS_CRC];
						state    <= S_END_ACK;
					end else if (ws_ok) begin
						xfer.start_read <= 1'b1;
						state           <= S_READING;
					end
				end

				S_READING: begin
					if (xfer.lost)
						lost_data <= 1'b1;
					if (xfer.done)
						state <= S_END_ACK;
				end

				// host fills the buffer, then workhorse flushes it
				S_WRITING: begin
					if (xfer.done) begin
						cpu_request <= REQ_WRITE | {7'b0, ctl.side};
						state       <= S_WAIT_WRITE;
					end
				end

				S_WAIT_WRITE: begin
					if (ws_fail) begin
						wr_fault <= cpu_status[WS_CRC];
						state    <= S_END_ACK;
					end else if (ws_ok) begin
						state <= S_END_ACK;
					end
				end

				S_ABORT: begin
					xfer.stop <= 1'b1;
					state     <= S_END_ACK;
				end

				S_END_ACK: begin
					cpu_request <= REQ_ACK;
					state       <= S_END_CLEAR;
				end

				// wait for workhorse to clear its status
				S_END_CLEAR: begin
					if (cpu_status == 8'h00) begin
						cpu_request <= REQ_IDLE;
						ctl.busy    <= 1'b0;
						state       <= S_IDLE;
					end
				end

				default: state <= S_IDLE;
			endcase

			// force-interrupt overrides whatever runs
			if (ctl.force_int) begin
				cmd_mode <= 1'b0;
				if (state == S_IDLE)
					{wr_fault, seek_err, crc_err, lost_data} <= 4'b0000;
				else
					state <= S_ABORT;
			end
		end
	end

	a_one_start: assert property (
		@(posedge clk) disable iff (!reset_n) !(xfer.start_read && xfer.start_write)
	);

endmodule

//--- fdc_sector_xfer.sv
`timescale 1ns/1ps

module fdc_sector_xfer #(
	parameter int SECTOR_SIZE  = 1024,
	parameter int DRQ_PACE     = 15,
	parameter int LOST_TIMEOUT = 2048
) (
	input  logic                    clk,
	input  logic                    reset_n,
	fdc_xfer_if.engine              xfer,
	input  logic                    data_rd,
	input  logic                    data_wr,
	input  fdc_bus_pkg::byte_t      data_in,
	input  fdc_bus_pkg::byte_t      buff_idata,
	output fdc_work_pkg::buf_addr_t buff_addr,
	output logic                    buff_rd,
	output logic                    buff_wr,
	output fdc_bus_pkg::byte_t      buff_odata
);
	import fdc_work_pkg::*;

	localparam int PACE_W = $clog2(DRQ_PACE + 2);
	localparam int WD_W   = $clog2(LOST_TIMEOUT + 2);

	localparam logic [PACE_W-1:0] PACE_LOAD = PACE_W'(DRQ_PACE);
	localparam logic [WD_W-1:0]   WD_LOAD   = WD_W'(LOST_TIMEOUT);
	localparam xfer_len_t         LAST_BYTE = xfer_len_t'(SECTOR_SIZE - 1);

	typedef enum logic [2:0] {
		X_IDLE,
		X_PACE,
		X_HOLD,
		X_NEXT,
		X_WR_WAIT,
		X_WR_STROBE,
		X_WR_ADV
	} xfer_state_t;

	xfer_state_t       state;
	xfer_len_t         count;
	logic [PACE_W-1:0] pace_cnt;
	logic [WD_W-1:0]   wd_cnt;

	// buffer always sees the data register on writes
	assign buff_odata = xfer.data_reg;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state         <= X_IDLE;
			count         <= '0;
			buff_addr     <= '0;
			buff_rd       <= 1'b0;
			buff_wr       <= 1'b0;
			pace_cnt      <= '0;
			wd_cnt        <= '0;
			xfer.done     <= 1'b0;
			xfer.lost     <= 1'b0;
			xfer.drq      <= 1'b0;
			xfer.data_reg <= 8'h00;
		end else begin
			xfer.done <= 1'b0;
			buff_wr   <= 1'b0;

			// host writes land here in any state, seek reads it too
			if (data_wr)
				xfer.data_reg <= data_in;

			case (state)
				X_IDLE: begin
					count     <= '0;
					buff_addr <= '0;
					if (xfer.start_read) begin
						xfer.lost <= 1'b0;
						buff_rd   <= 1'b1;
						pace_cnt  <= PACE_LOAD;
						state     <= X_PACE;
					end else if (xfer.start_write) begin
						xfer.lost <= 1'b0;
						xfer.drq  <= 1'b1;
						state     <= X_WR_WAIT;
					end
				end

				// ----------------------------------------
				// buffer to host
				// ----------------------------------------

				// give the buffer time, then present the byte
				X_PACE: begin
					if (pace_cnt != '0) begin
						pace_cnt <= pace_cnt - 1'b1;
					end else begin
						xfer.data_reg <= buff_idata;
						xfer.drq      <= 1'b1;
						buff_rd       <= 1'b0;
						wd_cnt        <= WD_LOAD;
						state         <= X_HOLD;
					end
				end

				// host read or watchdog expiry, both end the byte
				X_HOLD: begin
					if (wd_cnt != '0)
						wd_cnt <= wd_cnt - 1'b1;
					if (data_rd || wd_cnt == '0) begin
						xfer.drq <= 1'b0;
						if (wd_cnt == '0)
							xfer.lost <= 1'b1;
						state <= X_NEXT;
					end
				end

				X_NEXT: begin
					buff_addr <= buff_addr + 1'b1;
					count     <= count + 1'b1;
					if (count == LAST_BYTE) begin
						xfer.done <= 1'b1;
						state     <= X_IDLE;
					end else begin
						buff_rd  <= 1'b1;
						pace_cnt <= PACE_LOAD;
						state    <= X_PACE;
					end
				end

				// ----------------------------------------
				// host to buffer
				// ----------------------------------------

				X_WR_WAIT: begin
					if (data_wr) begin
						xfer.drq <= 1'b0;
						state    <= X_WR_STROBE;
					end
				end

				// data register is settled by now
				X_WR_STROBE: begin
					buff_wr <= 1'b1;
					state   <= X_WR_ADV;
				end

				X_WR_ADV: begin
					buff_addr <= buff_addr + 1'b1;
					count     <= count + 1'b1;
					if (count == LAST_BYTE) begin
						xfer.done <= 1'b1;
						state     <= X_IDLE;
					end else begin
						xfer.drq <= 1'b1;
						state    <= X_WR_WAIT;
					end
				end

				default: state <= X_IDLE;
			endcase

			// abort from the sequencer
			if (xfer.stop) begin
				xfer.drq <= 1'b0;
				buff_rd  <= 1'b0;
				buff_wr  <= 1'b0;
				state    <= X_IDLE;
			end
		end
	end

	a_rd_wr_exclusive: assert property (
		@(posedge clk) disable iff (!reset_n) !(buff_rd && buff_wr)
	);

endmodule

//--- fdc_top.sv
`timescale 1ns/1ps

module fdc_top #(
	parameter int SECTOR_SIZE  = 1024,
	parameter int DRQ_PACE     = 15,
	parameter int LOST_TIMEOUT = 2048
) (
	input  logic                    clk,
	input  logic                    reset_n,
	// host bus
	input  logic                    rd,
	input  logic                    wr,
	input  fdc_bus_pkg::reg_addr_t  addr,
	input  fdc_bus_pkg::byte_t      idata,
	output fdc_bus_pkg::byte_t      odata,
	// sector buffer
	output fdc_work_pkg::buf_addr_t buff_addr,
	output logic                    buff_rd,
	output logic                    buff_wr,
	input  fdc_bus_pkg::byte_t      buff_idata,
	output fdc_bus_pkg::byte_t      buff_odata,
	// workhorse
	output fdc_bus_pkg::byte_t      cpu_track,
	output fdc_bus_pkg::byte_t      cpu_sector,
	output fdc_bus_pkg::byte_t      cpu_status_out,
	output fdc_bus_pkg::byte_t      cpu_request,
	input  fdc_bus_pkg::byte_t      cpu_status,
	// flags
	output logic                    irq,
	output logic                    drq
);
	import fdc_bus_pkg::*;

	fdc_ctl_if  ctl_bus ();
	fdc_xfer_if xfer_bus ();

	// data port strobes between host block and engine
	logic  data_rd;
	logic  data_wr;
	byte_t data_in;

	fdc_host_regs u_host_regs (
		.clk      (clk),
		.reset_n  (reset_n),
		.rd       (rd),
		.wr       (wr),
		.addr     (addr),
		.idata    (idata),
		.odata    (odata),
		.data_rd  (data_rd),
		.data_wr  (data_wr),
		.data_in  (data_in),
		.ctl      (ctl_bus.host),
		.data_reg (xfer_bus.data_reg)
	);

	fdc_sequencer u_sequencer (
		.clk         (clk),
		.reset_n     (reset_n),
		.ctl         (ctl_bus.sequencer),
		.xfer        (xfer_bus.sequencer),
		.cpu_track   (cpu_track),
		.cpu_request (cpu_request),
		.cpu_status  (cpu_status)
	);

	fdc_sector_xfer #(
		.SECTOR_SIZE  (SECTOR_SIZE),
		.DRQ_PACE     (DRQ_PACE),
		.LOST_TIMEOUT (LOST_TIMEOUT)
	) u_sector_xfer (
		.clk        (clk),
		.reset_n    (reset_n),
		.xfer       (xfer_bus.engine),
		.data_rd    (data_rd),
		.data_wr    (data_wr),
		.data_in    (data_in),
		.buff_idata (buff_idata),
		.buff_addr  (buff_addr),
		.buff_rd    (buff_rd),
		.buff_wr    (buff_wr),
		.buff_odata (buff_odata)
	);

	// workhorse sees the sector register and the live status byte
	assign cpu_sector     = ctl_bus.sector_reg;
	assign cpu_status_out = ctl_bus.status;

	// irq follows busy
	assign irq = ctl_bus.busy;
	assign drq = xfer_bus.drq;

endmodule

//--- tb_fdc_tests.svh
// ----------------------------------------
// register file
// ----------------------------------------

task automatic register_readback();
	byte_t v;
	// state straight out of reset
	@(negedge clk);
	check_value("reset irq", 0, irq);
	check_value("reset drq", 0, drq);
	check_value("reset buff_rd", 0, buff_rd);
	check_value("reset buff_wr", 0, buff_wr);
	check_value("reset request", REQ_IDLE, cpu_request);
	check_value("reset head", 8'hFF, cpu_track);
	host_read(A_TRACK, v);
	check_value("reset track", 8'h00, v);

	host_write(A_TRACK, 8'h5A);
	host_write(A_SECTOR, 8'h07);
	host_read(A_TRACK, v);
	check_value("track readback", 8'h5A, v);
	host_read(A_SECTOR, v);
	check_value("sector readback", 8'h07, v);
	check_value("cpu_sector", 8'h07, cpu_sector);

	// side and drive both set and the rest reads high
	host_write(A_CTL2, 8'h05);
	host_read(A_CTL2, v);
	check_value("ctl2 readback", 8'hF8 | 8'h04 | 8'h01, v);
	host_read(3'd4, v);
	check_value("unused address", 8'hFF, v);
endtask

// ----------------------------------------
// type I
// ----------------------------------------

task automatic type1_exchange(input byte_t c, input byte_t req, input string name);
	issue_command(c);
	wait_cmd_end(name);
	// nop request carries the command nibble
	check_value({name, " request"}, req, req_seen);
endtask

task automatic type1_commands();
	byte_t v;
	host_write(A_DATA, 8'h2A);
	type1_exchange(8'h10, 8'h41, "seek");
	check_value("seek head", 8'h2A, cpu_track);

	// step-in with update from a known track
	host_write(A_TRACK, 8'h30);
	type1_exchange(8'h50, 8'h45, "step-in");
	check_value("step-in head", 8'h2B, cpu_track);
	host_read(A_TRACK, v);
	check_value("step-in track", 8'h31, v);

	// step-out moves the head only
	type1_exchange(8'h60, 8'h46, "step-out");
	check_value("step-out head", 8'h2A, cpu_track);
	host_read(A_TRACK, v);
	check_value("step-out track", 8'h31, v);

	type1_exchange(8'h00, 8'h40, "restore");
	check_value("restore head", 8'h00, cpu_track);
	// workhorse copy of the status byte
	check_value("restore status out", ST_TRACK0 | ST_INDEX, cpu_status_out);
	host_read(A_TRACK, v);
	check_value("restore track", 8'h00, v);
	host_read(A_CMD_STATUS, v);
	check_value("restore status", ST_TRACK0 | ST_INDEX, v);
endtask

// ----------------------------------------
// sector transfers
// ----------------------------------------

task automatic sector_read();
	byte_t v;
	int i;
	issue_command(8'h80);
	for (i = 0; i < SECTOR; i++) begin
		wait_drq();
		host_read(A_DATA, v);
		check_value("sector read data", image[i], v);
	end
	wait_cmd_end("sector read");
	// drive and side both set
	check_value("read request", 8'h13, req_seen);
	host_read(A_CMD_STATUS, v);
	check_value("read lost bit", 0, v[2]);
endtask

task automatic sector_write();
	int i;
	for (i = 0; i < SECTOR; i++) begin
		rng      = xorshift32(rng);
		wdata[i] = rng[7:0];
	end
	issue_command(8'hA0);
	for (i = 0; i < SECTOR; i++) begin
		wait_drq();
		host_write(A_DATA, wdata[i]);
	end
	wait_cmd_end("sector write");
	check_value("write request", 8'h21, req_seen);
	for (i = 0; i < SECTOR; i++)
		check_value("buffer byte", wdata[i], mem[i]);
endtask

// ----------------------------------------
// failures and abort
// ----------------------------------------

task automatic failure_and_lost_data();
	byte_t v;
	wh_fail = 1'b1;
	issue_command(8'h80);
	wait_cmd_end("read failure");
	wh_fail = 1'b0;
	host_read(A_CMD_STATUS, v);
	check_value("failure status", ST_RNF | ST_CRC, v);

	// without host reads the watchdog runs out on each byte
	issue_command(8'h80);
	wait_cmd_end("lost data");
	host_read(A_CMD_STATUS, v);
	check_value("lost status", ST_LOST, v);
endtask

task automatic force_interrupt();
	byte_t v;
	int n;
	issue_command(8'h80);
	wait_drq();
	host_write(A_CMD_STATUS, 8'hD0);
	// abort reaches the byte engine in a couple of cycles
	n = 0;
	@(negedge clk);
	while (drq && n < 8) begin
		@(negedge clk);
		n++;
	end
	check_value("force drq", 0, drq);
	wait_cmd_end("force interrupt");
	// type I layout with the head still on track 0
	host_read(A_CMD_STATUS, v);
	check_value("force status", ST_TRACK0, v);
endtask

//--- tb_fdc.sv
`timescale 1ns/1ps

module tb_fdc;
	import fdc_bus_pkg::*;
	import fdc_work_pkg::*;

	localparam int SECTOR   = 16;
	localparam int WH_DELAY = 5;
	// the lost-data read is the longest test at about 1100 cycles
	localparam int MAX_CYCLES = 20000;
	localparam logic [31:0] SEED = 32'h6be1d66c;

	// workhorse answers for done with ok or done with crc
	localparam byte_t WS_SUCCESS  = 8'h03;
	localparam byte_t WS_CRC_FAIL = 8'h05;

	// status bits in type I and type II layouts
	localparam byte_t ST_INDEX  = 8'h02;
	localparam byte_t ST_TRACK0 = 8'h04;
	localparam byte_t ST_LOST   = 8'h04;
	localparam byte_t ST_CRC    = 8'h08;
	localparam byte_t ST_RNF    = 8'h10;

	logic      clk;
	logic      reset_n;
	logic      rd;
	logic      wr;
	reg_addr_t addr;
	byte_t     idata;
	byte_t     odata;
	buf_addr_t buff_addr;
	logic      buff_rd;
	logic      buff_wr;
	byte_t     buff_idata;
	byte_t     buff_odata;
	byte_t     cpu_track;
	byte_t     cpu_sector;
	byte_t     cpu_status_out;
	byte_t     cpu_request;
	byte_t     cpu_status;
	logic      irq;
	logic      drq;

	// live buffer contents and the image they were filled from
	byte_t       mem [0:1023];
	byte_t       image [0:1023];
	byte_t       wdata [0:SECTOR-1];
	logic [31:0] rng;

	int    errors;
	int    checks;
	int    cycles;
	int    wh_count;
	logic  wh_fail;
	logic  ack_seen;
	byte_t req_seen;

	fdc_top #(
		.SECTOR_SIZE  (SECTOR),
		.DRQ_PACE     (3),
		.LOST_TIMEOUT (64)
	) uut (
		.clk            (clk),
		.reset_n        (reset_n),
		.rd             (rd),
		.wr             (wr),
		.addr           (addr),
		.idata          (idata),
		.odata          (odata),
		.buff_addr      (buff_addr),
		.buff_rd        (buff_rd),
		.buff_wr        (buff_wr),
		.buff_idata     (buff_idata),
		.buff_odata     (buff_odata),
		.cpu_track      (cpu_track),
		.cpu_sector     (cpu_sector),
		.cpu_status_out (cpu_status_out),
		.cpu_request    (cpu_request),
		.cpu_status     (cpu_status),
		.irq            (irq),
		.drq            (drq)
	);

	always #50 clk = ~clk;

	// ----------------------------------------
	// workhorse and buffer models
	// ----------------------------------------

	// answers any request after a delay and clears on ack
	always @(posedge clk) begin
		if (cpu_request == REQ_ACK) begin
			cpu_status <= 8'h00;
			wh_count   <= 0;
			ack_seen   <= 1'b1;
		end else if (cpu_request != REQ_IDLE && cpu_status == 8'h00) begin
			if (wh_count == WH_DELAY) begin
				req_seen   <= cpu_request;
				cpu_status <= wh_fail ? WS_CRC_FAIL : WS_SUCCESS;
				wh_count   <= 0;
			end else begin
				wh_count <= wh_count + 1;
			end
		end
	end

	// 1 KB sector buffer with registered read
	always @(posedge clk) begin
		if (buff_rd)
			buff_idata <= mem[buff_addr];
		if (buff_wr)
			mem[buff_addr] <= buff_odata;
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: a test never finished within %0d cycles", MAX_CYCLES);
			$display("checks %0d, errors %0d", checks, errors);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic fill_buffer();
		int a;
		rng = SEED;
		for (a = 0; a < 1024; a++) begin
			rng      = xorshift32(rng);
			mem[a]   = rng[7:0];
			image[a] = rng[7:0];
		end
	endtask

	// one host bus write with the strobe high for a single cycle
	task automatic host_write(input reg_addr_t a, input byte_t d);
		@(posedge clk);
		wr    <= 1'b1;
		addr  <= a;
		idata <= d;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	// readback sampled mid-cycle while rd is high
	task automatic host_read(input reg_addr_t a, output byte_t d);
		@(posedge clk);
		rd   <= 1'b1;
		addr <= a;
		@(negedge clk);
		d = odata;
		@(posedge clk);
		rd <= 1'b0;
	endtask

	task automatic wait_drq();
		@(negedge clk);
		while (!drq)
			@(negedge clk);
	endtask

	task automatic issue_command(input byte_t c);
		ack_seen = 1'b0;
		host_write(A_CMD_STATUS, c);
	endtask

	// busy up then down with the four-phase exchange complete
	task automatic wait_cmd_end(input string name);
		@(negedge clk);
		while (!irq)
			@(negedge clk);
		while (irq)
			@(negedge clk);
		check_value({name, " ack seen"}, 1, ack_seen);
		check_value({name, " workhorse status"}, 8'h00, cpu_status);
		check_value({name, " request idle"}, REQ_IDLE, cpu_request);
	endtask

	`include "tb_fdc_tests.svh"

	initial begin
		clk        = 1'b0;
		reset_n    = 1'b0;
		rd         = 1'b0;
		wr         = 1'b0;
		addr       = A_CMD_STATUS;
		idata      = 8'h00;
		buff_idata = 8'h00;
		cpu_status = 8'h00;
		wh_fail    = 1'b0;
		ack_seen   = 1'b0;
		req_seen   = 8'h00;
		errors     = 0;
		checks     = 0;
		cycles     = 0;
		wh_count   = 0;
		fill_buffer();
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;

		register_readback();
		type1_commands();
		sector_read();
		sector_write();
		failure_and_lost_data();
		force_interrupt();

		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
fdc_bus_pkg.sv
fdc_work_pkg.sv
fdc_if.sv
fdc_host_regs.sv
fdc_sequencer.sv
fdc_sector_xfer.sv
fdc_top.sv
tb_fdc.sv

//--- Bender.yml
package:
  name: fdc_wd1793

sources:
  # packages, interfaces, engines, then the top level
  - files:
      - fdc_bus_pkg.sv
      - fdc_work_pkg.sv
      - fdc_if.sv
      - fdc_host_regs.sv
      - fdc_sequencer.sv
      - fdc_sector_xfer.sv
      - fdc_top.sv

  # testbench, includes its test tasks from the root
  - target: test
    include_dirs:
      - .
    files:
      - tb_fdc.sv
